//--- dv/cam_display_stimulus.txt
// kind addr rgb565 gray, all hex. kind 1 writes a pixel and gives its luma,
// kind 2 starts the next checked frame with sw_grayscale = rgb565 field bit 0, kind 0 ends
1 000 FFFF FF
1 00F F800 4C
1 010 07E0 95
1 01F 001F 1C
1 020 8410 82
1 033 7BEF 7C
1 03E FFE0 E2
1 03F 07FF B2
1 040 F81F 69
1 041 1234 3F
1 047 ABCD 87
1 055 5555 8F
1 05A AAAA 6F
1 060 39E7 3A
1 070 C618 C4
1 07F 0000 00
// frame 1 in color, frame 2 in gray
2 000 0000 00
2 000 0001 00
// rewrites across the bank boundary before frame 3
1 040 0841 08
1 03F FC00 98
1 07F FFFF FF
2 000 0001 00
0 000 0000 00

//--- filelist.f
design/cam_display_pkg.sv
design/vga_timing.sv
design/pixel_bank_ram.sv
design/frame_buffer.sv
design/pixel_color_path.sv
design/cam_display_top.sv
dv/tb_cam_display.sv

//--- run_sim.sh
#!/bin/sh
# build and run tb_cam_display with Verilator from the project root
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -f filelist.f --top-module tb_cam_display
./obj_dir/Vtb_cam_display | tee sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

//--- dv/tb_cam_display.sv
// ==========================================================================
// reads dv/cam_display_stimulus.txt relative to the project root
// small 16x8 image on a 32x16 raster, RGB of frame 0 is open while it loads
// ==========================================================================
`timescale 1ns/100ps

module tb_cam_display;

    localparam int IMG_W      = 16;
    localparam int IMG_H      = 8;
    localparam int BANK_WORDS = 64;
    localparam int H_FRONT    = 4;
    localparam int H_SYNC     = 8;
    localparam int H_BACK     = 4;
    localparam int V_FRONT    = 2;
    localparam int V_SYNC     = 2;
    localparam int V_BACK     = 3;

    localparam int NPIX      = IMG_W * IMG_H;
    localparam int H_ACT     = 2 * IMG_W;
    localparam int V_ACT     = 2 * IMG_H;
    localparam int H_TOTAL   = H_ACT + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL   = V_ACT + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYC = H_TOTAL * V_TOTAL;
    localparam int PIPE_LAT  = 2;              // read address to RGB out
    localparam int CLK_HALF  = 10;
    localparam int DRIVE_DLY = 2;
    localparam int RESET_CYC = 16;
    localparam int STIM_RECS = 32;             // four words per record
    localparam int LOAD_CYC  = 2 * NPIX + STIM_RECS;
    localparam int LUMA_WR   = 77;
    localparam int LUMA_WG   = 150;
    localparam int LUMA_WB   = 29;

    logic        clk_25_vga = 1'b0;
    logic        arst_n;
    logic        wr_en;
    logic [16:0] wr_addr;
    logic [15:0] wr_data;
    logic        sw_grayscale;
    logic        vga_hsync;
    logic        vga_vsync;
    logic        vga_blank_n;
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;

    logic [31:0] stim [4 * STIM_RECS];
    logic [15:0] img [NPIX];                   // model of the frame buffer
    logic [7:0]  gray_img [NPIX];
    bit          listed [NPIX];
    integer      seed = 32'hf72f_d2ba;

    bit          started;                      // first blank_n rise seen
    bit          exp_gray;
    int          pos;
    int          rel_cnt;
    int          mon_h;
    int          mon_v;
    int          mon_frame;
    int          n_frames;

    cam_display_top #(
        .IMG_W      (IMG_W),
        .IMG_H      (IMG_H),
        .BANK_WORDS (BANK_WORDS),
        .H_FRONT    (H_FRONT),
        .H_SYNC     (H_SYNC),
        .H_BACK     (H_BACK),
        .V_FRONT    (V_FRONT),
        .V_SYNC     (V_SYNC),
        .V_BACK     (V_BACK)
    ) dut_i (
        .clk_25_vga   (clk_25_vga),
        .arst_n       (arst_n),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .sw_grayscale (sw_grayscale),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_blank_n  (vga_blank_n),
        .vga_r        (vga_r),
        .vga_g        (vga_g),
        .vga_b        (vga_b)
    );

    always #(CLK_HALF) clk_25_vga = !clk_25_vga;

    // top bits copied into the low bits
    function automatic logic [7:0] expand_red(input logic [15:0] p);
        return {p[15:11], p[15:13]};
    endfunction

    function automatic logic [7:0] expand_green(input logic [15:0] p);
        return {p[10:5], p[10:9]};
    endfunction

    function automatic logic [7:0] expand_blue(input logic [15:0] p);
        return {p[4:0], p[4:2]};
    endfunction

    function automatic logic [7:0] luma_of(input logic [15:0] p);
        int sum;
        sum = LUMA_WR * int'(expand_red(p)) + LUMA_WG * int'(expand_green(p))
            + LUMA_WB * int'(expand_blue(p));
        return 8'(sum >> 8);
    endfunction

    function automatic int kind_of(input int rec);
        if (rec >= STIM_RECS) begin
            return 0;
        end
        return int'(stim[4 * rec]);
    endfunction

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            abort_run();
        end
    endtask

    task automatic check_rgb(input logic [7:0] r, input logic [7:0] g, input logic [7:0] b);
        check_val("vga_r", 32'(vga_r), 32'(r));
        check_val("vga_g", 32'(vga_g), 32'(g));
        check_val("vga_b", 32'(vga_b), 32'(b));
    endtask

    // expected outputs at the current raster position
    task automatic check_raster();
        logic        act;
        logic        hs;
        logic        vs;
        int          a;
        logic [15:0] p;
        act = (mon_h < H_ACT) && (mon_v < V_ACT);
        hs  = !((mon_h >= H_ACT + H_FRONT) && (mon_h < H_ACT + H_FRONT + H_SYNC));
        vs  = !((mon_v >= V_ACT + V_FRONT) && (mon_v < V_ACT + V_FRONT + V_SYNC));
        check_val("vga_hsync", 32'(vga_hsync), 32'(hs));
        check_val("vga_vsync", 32'(vga_vsync), 32'(vs));
        check_val("vga_blank_n", 32'(vga_blank_n), 32'(act));
        if (!act) begin
            check_rgb(8'h00, 8'h00, 8'h00);
        end else if (mon_frame >= 1) begin     // frame 0 is still loading
            a = (mon_v / 2) * IMG_W + mon_h / 2;
            p = img[a];
            if (exp_gray) begin
                check_rgb(gray_img[a], gray_img[a], gray_img[a]);
            end else begin
                check_rgb(expand_red(p), expand_green(p), expand_blue(p));
            end
        end
    endtask

    // sampled on the falling edge while outputs move on the rising one
    always @(negedge clk_25_vga) begin
        if (!started) begin
            check_val("vga_hsync", 32'(vga_hsync), 32'd1);
            check_val("vga_vsync", 32'(vga_vsync), 32'd1);
            if (vga_blank_n === 1'b1) begin
                if (rel_cnt != PIPE_LAT) begin
                    $display("first active pixel came %0d cycles after reset release", rel_cnt);
                    abort_run();
                end
                started = 1'b1;
                pos     = 0;
            end else begin
                check_val("vga_blank_n", 32'(vga_blank_n), 32'd0);
                check_rgb(8'h00, 8'h00, 8'h00);
                if (arst_n) begin
                    rel_cnt++;
                end
            end
        end
        if (started) begin
            mon_h     = pos % H_TOTAL;
            mon_v     = (pos / H_TOTAL) % V_TOTAL;
            mon_frame = pos / FRAME_CYC;
            check_raster();
            pos++;
        end
    end

    // called at the drive point and returns one clock later at the drive point
    task automatic write_pixel(input int addr, input logic [15:0] data);
        wr_en   = 1'b1;
        wr_addr = 17'(addr);
        wr_data = data;
        @(posedge clk_25_vga);
        #(DRIVE_DLY);
    endtask

    task automatic apply_record(input int rec);
        int a;
        a = int'(stim[4 * rec + 1]);
        if (a < 0 || a >= NPIX) begin
            $display("stimulus record %0d has an address outside the image", rec);
            abort_run();
        end
        img[a]      = stim[4 * rec + 2][15:0];
        gray_img[a] = stim[4 * rec + 3][7:0];
        listed[a]   = 1'b1;
        write_pixel(a, img[a]);
    endtask

    task automatic wait_vblank(input int frame);
        do begin
            @(posedge clk_25_vga);
            if (mon_frame > frame) begin
                $display("stimulus fell behind the raster before frame %0d", frame + 1);
                abort_run();
            end
        end while (!(started && mon_frame == frame && mon_v >= V_ACT));
        #(DRIVE_DLY);
    endtask

    initial begin
        int i;
        int rec;
        int frame;
        int rnd;
        int cnt;
        arst_n       = 1'b0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        sw_grayscale = 1'b0;
        exp_gray     = 1'b0;
        started      = 1'b0;
        pos          = 0;
        rel_cnt      = 0;
        mon_h        = 0;
        mon_v        = 0;
        mon_frame    = 0;
        n_frames     = 0;
        for (i = 0; i < NPIX; i++) begin
            img[i]      = '0;
            gray_img[i] = '0;
            listed[i]   = 1'b0;
        end
        for (i = 0; i < 4 * STIM_RECS; i++) begin
            stim[i] = '0;    // unread records end the program
        end
        $readmemh("dv/cam_display_stimulus.txt", stim);
        cnt = 0;
        for (rec = 0; rec < STIM_RECS; rec++) begin
            if (kind_of(rec) == 2) begin
                cnt++;
            end
        end
        if (cnt == 0) begin
            $display("stimulus file holds no mode record");
            abort_run();
        end
        n_frames = cnt;

        repeat (RESET_CYC) @(posedge clk_25_vga);
        #(DRIVE_DLY);
        arst_n = 1'b1;

        for (i = 0; i < NPIX; i++) begin
            write_pixel(i, 16'h0000);
        end
        rec = 0;
        while (kind_of(rec) == 1) begin
            apply_record(rec);
            rec++;
        end
        for (i = 0; i < NPIX; i++) begin
            if (!listed[i]) begin
                rnd         = $random(seed);
                img[i]      = rnd[15:0];
                gray_img[i] = luma_of(img[i]);
                write_pixel(i, img[i]);
            end
        end
        wr_en = 1'b0;

        // each mode record starts a checked frame and its rewrites land in the vblank before it
        frame = 0;
        while (kind_of(rec) != 0) begin
            wait_vblank(frame);
            while (kind_of(rec) == 1) begin
                apply_record(rec);
                rec++;
            end
            wr_en = 1'b0;
            if (kind_of(rec) == 2) begin
                sw_grayscale = stim[4 * rec + 2][0];
                exp_gray     = stim[4 * rec + 2][0];
                frame++;
                rec++;
            end else if (kind_of(rec) != 0) begin
                $display("stimulus record %0d has an unknown kind", rec);
                abort_run();
            end
        end
        do begin
            @(posedge clk_25_vga);
        end while (mon_frame <= frame);
        $display("ALL TESTS PASSED");
        $finish;
    end

    // load overlaps frame 0 and each checked frame adds one period
    initial begin
        wait (n_frames > 0);
        #((RESET_CYC + LOAD_CYC + (n_frames + 1) * FRAME_CYC) * 2 * CLK_HALF);
        $display("timeout, the checked frames did not complete in time");
        abort_run();
    end

endmodule

//--- design/cam_display_top.sv
// ==========================================================================
// display side of the camera board, everything on clk_25_vga
// frame buffer written through a one-cycle strobe, no back-pressure
// ==========================================================================
`timescale 1ns/100ps

module cam_display_top #(
    parameter int IMG_W      = cam_display_pkg::DEF_IMG_W,
    parameter int IMG_H      = cam_display_pkg::DEF_IMG_H,
    parameter int BANK_WORDS = cam_display_pkg::DEF_BANK_WORDS,
    parameter int H_FRONT    = cam_display_pkg::DEF_H_FRONT,
    parameter int H_SYNC     = cam_display_pkg::DEF_H_SYNC,
    parameter int H_BACK     = cam_display_pkg::DEF_H_BACK,
    parameter int V_FRONT    = cam_display_pkg::DEF_V_FRONT,
    parameter int V_SYNC     = cam_display_pkg::DEF_V_SYNC,
    parameter int V_BACK     = cam_display_pkg::DEF_V_BACK
) (
    input  logic                       clk_25_vga,
    input  logic                       arst_n,
    input  logic                       wr_en,
    input  cam_display_pkg::pix_addr_t wr_addr,
    input  cam_display_pkg::rgb565_t   wr_data,
    input  logic                       sw_grayscale,
    output logic                       vga_hsync,
    output logic                       vga_vsync,
    output logic                       vga_blank_n,
    output cam_display_pkg::chan8_t    vga_r,
    output cam_display_pkg::chan8_t    vga_g,
    output cam_display_pkg::chan8_t    vga_b
);

    import cam_display_pkg::*;

    pix_addr_t rd_addr;
    logic      rd_active;
    rgb565_t   rd_data;     // one clock behind rd_addr

    vga_timing #(
        .IMG_W   (IMG_W),
        .IMG_H   (IMG_H),
        .H_FRONT (H_FRONT),
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .V_FRONT (V_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK)
    ) timing_i (
        .clk_25_vga  (clk_25_vga),
        .arst_n      (arst_n),
        .rd_addr     (rd_addr),
        .rd_active   (rd_active),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_blank_n (vga_blank_n)
    );

    frame_buffer #(
        .BANK_WORDS (BANK_WORDS),
        .IMG_W      (IMG_W),
        .IMG_H      (IMG_H)
    ) fb_i (
        .clk_25_vga (clk_25_vga),
        .arst_n     (arst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    pixel_color_path color_i (
        .clk_25_vga   (clk_25_vga),
        .arst_n       (arst_n),
        .rd_data      (rd_data),
        .rd_active    (rd_active),   // delayed inside to match the ram
        .sw_grayscale (sw_grayscale),
        .vga_r        (vga_r),
        .vga_g        (vga_g),
        .vga_b        (vga_b)
    );

endmodule

//--- design/pixel_color_path.sv
// ==========================================================================
// RGB565 to RGB888 by bit replication, optional BT.601 luma on all channels
// output registered, zero outside the active area
// ==========================================================================
`timescale 1ns/100ps

module pixel_color_path (
    input  logic                     clk_25_vga,
    input  logic                     arst_n,
    input  cam_display_pkg::rgb565_t rd_data,
    input  logic                     rd_active,
    input  logic                     sw_grayscale,
    output cam_display_pkg::chan8_t  vga_r,
    output cam_display_pkg::chan8_t  vga_g,
    output cam_display_pkg::chan8_t  vga_b
);

    import cam_display_pkg::*;

    logic        active_d1;    // matches the ram read cycle
    chan8_t      r8;
    chan8_t      g8;
    chan8_t      b8;
    logic [15:0] luma_sum;     // max 256*255 fits
    chan8_t      luma;

    // top bits copied down so full scale maps to 255
    assign r8 = {rd_data.r5, rd_data.r5[4:2]};
    assign g8 = {rd_data.g6, rd_data.g6[5:4]};
    assign b8 = {rd_data.b5, rd_data.b5[4:2]};

    assign luma_sum = 16'(LUMA_WR * r8 + LUMA_WG * g8 + LUMA_WB * b8);
    assign luma     = luma_sum[15:8];

    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            active_d1 <= 1'b0;
        end else begin
            active_d1 <= rd_active;
        end
    end

    // second pipeline stage
    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            vga_r <= '0;
            vga_g <= '0;
            vga_b <= '0;
        end else if (!active_d1) begin
            vga_r <= '0;    // blanking
            vga_g <= '0;
            vga_b <= '0;
        end else if (sw_grayscale) begin
            vga_r <= luma;
            vga_g <= luma;
            vga_b <= luma;
        end else begin
            vga_r <= r8;
            vga_g <= g8;
            vga_b <= b8;
        end
    end

endmodule

//--- design/frame_buffer.sv
// ==========================================================================
// two-bank frame buffer split at BANK_WORDS, addresses must be below
// IMG_W*IMG_H, read data follows rd_addr by one clock
// ==========================================================================
`timescale 1ns/100ps

module frame_buffer #(
    parameter int BANK_WORDS = cam_display_pkg::DEF_BANK_WORDS,
    parameter int IMG_W      = cam_display_pkg::DEF_IMG_W,
    parameter int IMG_H      = cam_display_pkg::DEF_IMG_H
) (
    input  logic                       clk_25_vga,
    input  logic                       arst_n,
    input  logic                       wr_en,
    input  cam_display_pkg::pix_addr_t wr_addr,
    input  cam_display_pkg::rgb565_t   wr_data,
    input  cam_display_pkg::pix_addr_t rd_addr,
    output cam_display_pkg::rgb565_t   rd_data
);

    import cam_display_pkg::*;

    localparam int B1_DEPTH = IMG_W * IMG_H - BANK_WORDS;
    localparam int B0_AW    = $clog2(BANK_WORDS);
    localparam int B1_AW    = $clog2(B1_DEPTH);

    logic             wr_hi;          // write targets bank 1
    logic             rd_hi;
    logic             rd_hi_q;        // lines up with ram latency
    logic [B0_AW-1:0] b0_waddr;
    logic [B0_AW-1:0] b0_raddr;
    logic [B1_AW-1:0] b1_waddr;
    logic [B1_AW-1:0] b1_raddr;
    rgb565_t          b0_rdata;
    rgb565_t          b1_rdata;

    assign wr_hi = (wr_addr >= pix_addr_t'(BANK_WORDS));
    assign rd_hi = (rd_addr >= pix_addr_t'(BANK_WORDS));

    assign b0_waddr = B0_AW'(wr_addr);
    assign b0_raddr = B0_AW'(rd_addr);
    assign b1_waddr = B1_AW'(wr_addr - pix_addr_t'(BANK_WORDS)); // bank 1 starts at zero
    assign b1_raddr = B1_AW'(rd_addr - pix_addr_t'(BANK_WORDS));

    pixel_bank_ram #(.DEPTH(BANK_WORDS)) bank0_i (
        .clk_25_vga (clk_25_vga),
        .we         (wr_en && !wr_hi),
        .waddr      (b0_waddr),
        .wdata      (wr_data),
        .raddr      (b0_raddr),
        .rdata      (b0_rdata)
    );

    pixel_bank_ram #(.DEPTH(B1_DEPTH)) bank1_i (
        .clk_25_vga (clk_25_vga),
        .we         (wr_en && wr_hi),
        .waddr      (b1_waddr),
        .wdata      (wr_data),
        .raddr      (b1_raddr),
        .rdata      (b1_rdata)
    );

    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            rd_hi_q <= 1'b0;
        end else begin
            rd_hi_q <= rd_hi;
        end
    end

    assign rd_data = rd_hi_q ? b1_rdata : b0_rdata;

endmodule

//--- design/pixel_bank_ram.sv
// ==========================================================================
// simple dual-port pixel memory, read data valid one clock after raddr
// a read of the address being written returns the old word
// ==========================================================================
`timescale 1ns/100ps

module pixel_bank_ram #(
    parameter int DEPTH = 32768
) (
    input  logic                         clk_25_vga,
    input  logic                         we,
    input  logic [$clog2(DEPTH)-1:0]     waddr,
    input  cam_display_pkg::rgb565_t     wdata,
    input  logic [$clog2(DEPTH)-1:0]     raddr,
    output cam_display_pkg::rgb565_t     rdata
);

    import cam_display_pkg::*;

    rgb565_t mem [DEPTH];    // maps to block ram

    always_ff @(posedge clk_25_vga) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];     // registered read
    end

endmodule

//--- design/vga_timing.sv
// ==========================================================================
// raster counters start on the first active pixel after reset release
// sync outputs are active low and delayed by PIPE_LAT to match the RGB path
// ==========================================================================
`timescale 1ns/100ps

module vga_timing #(
    parameter int IMG_W   = cam_display_pkg::DEF_IMG_W,
    parameter int IMG_H   = cam_display_pkg::DEF_IMG_H,
    parameter int H_FRONT = cam_display_pkg::DEF_H_FRONT,
    parameter int H_SYNC  = cam_display_pkg::DEF_H_SYNC,
    parameter int H_BACK  = cam_display_pkg::DEF_H_BACK,
    parameter int V_FRONT = cam_display_pkg::DEF_V_FRONT,
    parameter int V_SYNC  = cam_display_pkg::DEF_V_SYNC,
    parameter int V_BACK  = cam_display_pkg::DEF_V_BACK
) (
    input  logic                      clk_25_vga,
    input  logic                      arst_n,
    output cam_display_pkg::pix_addr_t rd_addr,
    output logic                      rd_active,
    output logic                      vga_hsync,
    output logic                      vga_vsync,
    output logic                      vga_blank_n
);

    import cam_display_pkg::*;

    localparam int H_ACT   = 2 * IMG_W;    // doubled horizontally
    localparam int V_ACT   = 2 * IMG_H;
    localparam int H_TOTAL = H_ACT + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACT + V_FRONT + V_SYNC + V_BACK;
    localparam int HCW     = $clog2(H_TOTAL);
    localparam int VCW     = $clog2(V_TOTAL);

    logic [HCW-1:0] h_cnt;
    logic [VCW-1:0] v_cnt;
    logic           h_last;
    logic           v_last;
    logic           h_act;
    logic           v_act;
    logic           hsync_raw;
    logic           vsync_raw;
    logic           blank_n_raw;
    pix_addr_t      row_base;      // (y/2)*IMG_W, kept as a running sum

    logic [PIPE_LAT-1:0] hsync_pipe;
    logic [PIPE_LAT-1:0] vsync_pipe;
    logic [PIPE_LAT-1:0] blank_pipe;

    assign h_last = (h_cnt == HCW'(H_TOTAL - 1));
    assign v_last = (v_cnt == VCW'(V_TOTAL - 1));
    assign h_act  = (h_cnt < HCW'(H_ACT));
    assign v_act  = (v_cnt < VCW'(V_ACT));

    // pixel and line counters, row base steps every second line
    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt    <= '0;
            v_cnt    <= '0;
            row_base <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            if (v_last) begin
                v_cnt    <= '0;
                row_base <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
                if (v_cnt[0]) begin
                    row_base <= row_base + pix_addr_t'(IMG_W); // leaving an odd line
                end
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // sync pulses sit after the front porch
    assign hsync_raw = !((h_cnt >= HCW'(H_ACT + H_FRONT)) &&
                         (h_cnt <  HCW'(H_ACT + H_FRONT + H_SYNC)));
    assign vsync_raw = !((v_cnt >= VCW'(V_ACT + V_FRONT)) &&
                         (v_cnt <  VCW'(V_ACT + V_FRONT + V_SYNC)));

    assign rd_active   = h_act && v_act;
    assign blank_n_raw = rd_active;

    // x/2 within the current source row
    assign rd_addr = rd_active ? (row_base + pix_addr_t'(h_cnt >> 1)) : '0;

    // align sync and blank with the ram read and the color register
    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            hsync_pipe <= '1;
            vsync_pipe <= '1;
            blank_pipe <= '0;    // blanked until the first pixel reaches the output
        end else begin
            hsync_pipe <= {hsync_pipe[PIPE_LAT-2:0], hsync_raw};
            vsync_pipe <= {vsync_pipe[PIPE_LAT-2:0], vsync_raw};
            blank_pipe <= {blank_pipe[PIPE_LAT-2:0], blank_n_raw};
        end
    end

    assign vga_hsync   = hsync_pipe[PIPE_LAT-1];
    assign vga_vsync   = vsync_pipe[PIPE_LAT-1];
    assign vga_blank_n = blank_pipe[PIPE_LAT-1];

endmodule

//--- design/cam_display_pkg.sv
// ==========================================================================
// shared pixel types and default VGA raster, single clock domain only
// luma weights are BT.601 scaled by 256, result taken as sum >> 8
// ==========================================================================
package cam_display_pkg;

    // stored pixel, msb first
    typedef struct packed {
        logic [4:0] r5;
        logic [5:0] g6;
        logic [4:0] b5;
    } rgb565_t;

    typedef logic [7:0]  chan8_t;
    typedef logic [16:0] pix_addr_t;    // covers 320x240 = 76800 words

    // stored image, shown doubled on 640x480
    localparam int DEF_IMG_W = 320;
    localparam int DEF_IMG_H = 240;

    // bank 0 holds words below this boundary
    localparam int DEF_BANK_WORDS = 32768;

    // horizontal porches in pixel clocks
    localparam int DEF_H_FRONT = 16;
    localparam int DEF_H_SYNC  = 96;
    localparam int DEF_H_BACK  = 48;

    // vertical porches in lines
    localparam int DEF_V_FRONT = 10;
    localparam int DEF_V_SYNC  = 2;
    localparam int DEF_V_BACK  = 33;

    // read address to RGB out, ram read plus output register
    localparam int PIPE_LAT = 2;

    localparam int LUMA_WR = 77;
    localparam int LUMA_WG = 150;
    localparam int LUMA_WB = 29;

endpackage
